/* build.f */
+incdir+dv
hdl/cplx_pkg.sv
hdl/dsp_slice.sv
hdl/complex_alu.sv
hdl/result_fifo.sv
hdl/cplx_wb_regs.sv
hdl/cplx_unit_top.sv
dv/tb_cplx_unit.sv

/* dv/cplx_wb_bfm.svh */
//////////////////////////////
// wishbone classic master, inputs change on the falling edge
// each access gives up after limit cycles without ack

task automatic wb_write(
	input  logic [cplx_pkg::ADR_W-1:0]  adr,
	input  logic [cplx_pkg::CPLX_W-1:0] dat,
	input  int                          limit,
	output bit                          acked
);
	int n;
	acked = 1'b0;
	n = 0;
	@(negedge clk);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = 1'b1;
	wb_adr   = adr;
	wb_dat_w = dat;
	while (!acked && n < limit) begin
		@(negedge clk);
		n++;
		acked = wb_ack;
	end
	if (acked) begin
		@(negedge clk); // stb held over the edge closing the ack cycle
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

task automatic wb_read(
	input  logic [cplx_pkg::ADR_W-1:0]  adr,
	output logic [cplx_pkg::CPLX_W-1:0] dat,
	input  int                          limit,
	output bit                          acked
);
	int n;
	acked = 1'b0;
	dat = '0;
	n = 0;
	@(negedge clk);
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we  = 1'b0;
	wb_adr = adr;
	while (!acked && n < limit) begin
		@(negedge clk);
		n++;
		acked = wb_ack;
	end
	if (acked) begin
		dat = wb_dat_r; // read data valid during the ack cycle
		@(negedge clk); // result pop happens on this edge
	end
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
endtask

/* dv/tb_cplx_unit.sv */
`timescale 1ns/100ps

module tb_cplx_unit;

	localparam int ACK_LIMIT  = 40;
	localparam int POLL_LIMIT = 30;
	localparam int STALL_WAIT = 20; // cycles a stalled launch is given

	logic                        clk;
	logic                        rst_n;
	logic                        wb_cyc, wb_stb, wb_we;
	logic [cplx_pkg::ADR_W-1:0]  wb_adr;
	logic [cplx_pkg::CPLX_W-1:0] wb_dat_w, wb_dat_r;
	logic                        wb_ack;

	int                          errors;
	int                          checks;
	integer                      seed;
	logic [cplx_pkg::CPLX_W-1:0] opa_m, opb_m; // operands as last written
	logic [cplx_pkg::CPLX_W-1:0] exp_word;
	logic [cplx_pkg::CPLX_W-1:0] exp_q [$];

	cplx_unit_top dut_i (
		.clk(clk), .rst_n_i(rst_n),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
		.wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
	);

	`include "cplx_wb_bfm.svh"

	initial clk = 1'b0;
	always #10 clk = ~clk;

	//////////////////////////////
	// reference model
	function automatic logic [cplx_pkg::DATA_W-1:0] q15_mul(
		input logic signed [cplx_pkg::DATA_W-1:0] x,
		input logic signed [cplx_pkg::DATA_W-1:0] y
	);
		logic signed [2*cplx_pkg::DATA_W-1:0] full;
		full = x * y;
		return full >>> cplx_pkg::FRAC_W; // truncates toward minus infinity
	endfunction

	function automatic logic [cplx_pkg::CPLX_W-1:0] ref_cplx(
		input logic [cplx_pkg::CPLX_W-1:0] opa,
		input logic [cplx_pkg::CPLX_W-1:0] opb,
		input logic [1:0]                  op
	);
		logic signed [cplx_pkg::DATA_W-1:0] a, b, c, d;
		logic [cplx_pkg::DATA_W-1:0]        re, im;
		{a, b} = opa;
		{c, d} = opb;
		case (op)
			cplx_pkg::OP_CMUL: begin
				re = q15_mul(a, c) + q15_mul(b, d);
				im = q15_mul(b, c) - q15_mul(a, d);
			end
			cplx_pkg::OP_ADD: begin
				re = a + c; // modulo 2^16
				im = b + d;
			end
			default: begin
				re = q15_mul(a, c) - q15_mul(b, d);
				im = q15_mul(b, c) + q15_mul(a, d);
			end
		endcase
		return {re, im};
	endfunction

	//////////////////////////////
	// bus monitor, expected results and read compare
	always @(negedge clk) begin
		if (rst_n && wb_ack && wb_cyc && wb_stb) begin
			if (wb_we) begin
				case (wb_adr)
					cplx_pkg::ADR_OPA:  opa_m = wb_dat_w;
					cplx_pkg::ADR_OPB:  opb_m = wb_dat_w;
					cplx_pkg::ADR_CTRL: exp_q.push_back(ref_cplx(opa_m, opb_m, wb_dat_w[1:0]));
					default: ;
				endcase
			end else if (wb_adr == cplx_pkg::ADR_RESULT) begin
				exp_word = '0; // empty fifo reads zero
				if (exp_q.size() != 0) begin
					exp_word = exp_q.pop_front();
				end
				checks++;
				if (wb_dat_r !== exp_word) begin
					$display("Error res_o: expected %h, got %h", exp_word, wb_dat_r);
					errors++;
				end
			end
		end
	end

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			$display("Error %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [cplx_pkg::ADR_W-1:0] adr, input logic [31:0] dat);
		bit acked;
		wb_write(adr, dat, ACK_LIMIT, acked);
		if (!acked) begin
			$display("write to address %0d got no ack within %0d cycles", adr, ACK_LIMIT);
			errors++;
		end
	endtask

	task automatic read_reg(input logic [cplx_pkg::ADR_W-1:0] adr, output logic [31:0] dat);
		bit acked;
		wb_read(adr, dat, ACK_LIMIT, acked);
		if (!acked) begin
			$display("read from address %0d got no ack within %0d cycles", adr, ACK_LIMIT);
			errors++;
		end
	endtask

	task automatic launch_op(input logic [31:0] opa, input logic [31:0] opb, input logic [1:0] op);
		write_reg(cplx_pkg::ADR_OPA, opa);
		write_reg(cplx_pkg::ADR_OPB, opb);
		write_reg(cplx_pkg::ADR_CTRL, {30'd0, op});
	endtask

	// polls STATUS until the fifo holds at least n results
	task automatic wait_level(input int n);
		logic [31:0] lvl;
		int          polls;
		lvl = '0;
		polls = 0;
		while (lvl < n && polls < POLL_LIMIT) begin
			read_reg(cplx_pkg::ADR_STATUS, lvl);
			polls++;
		end
		if (lvl < n) begin
			$display("result fifo level stayed below %0d", n);
			errors++;
		end
	endtask

	task automatic run_one(input logic [31:0] opa, input logic [31:0] opb, input logic [1:0] op,
		output logic [31:0] got);
		launch_op(opa, opb, op);
		wait_level(1);
		read_reg(cplx_pkg::ADR_RESULT, got);
	endtask

	//////////////////////////////
	// stimulus
	initial begin
		logic [31:0] rd;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [1:0]  rop;
		bit          acked;
		errors = 0;
		checks = 0;
		seed = 49061;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		// directed multiplies, near full scale, j*j and zero
		run_one(32'h7fff_0000, 32'h7fff_0000, cplx_pkg::OP_MUL, rd);
		check_word("res_o", 32'h7ffe_0000, rd);
		run_one(32'h0000_7fff, 32'h0000_7fff, cplx_pkg::OP_MUL, rd);
		check_word("res_o", 32'h8002_0000, rd);
		run_one(32'h1234_5678, 32'h0000_0000, cplx_pkg::OP_MUL, rd);
		check_word("res_o", 32'h0000_0000, rd);
		run_one(32'h8000_0000, 32'h8000_0000, cplx_pkg::OP_MUL, rd);
		run_one(32'h4000_4000, 32'h4000_c000, 2'd3, rd); // code 3 acts as multiply

		for (int i = 0; i < 200; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			rop = 2'($unsigned($random(seed)) % 3);
			run_one(ra, rb, rop, rd);
		end

		// add wraps in both halves
		run_one(32'h7fff_8000, 32'h0001_ffff, cplx_pkg::OP_ADD, rd);
		check_word("res_o", 32'h8000_7fff, rd);

		//////////////////////////////
		// fill the fifo, ninth launch must stall
		for (int i = 0; i < cplx_pkg::FIFO_DEPTH; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			launch_op(ra, rb, 2'(i % 3));
		end
		wait_level(cplx_pkg::FIFO_DEPTH);
		read_reg(cplx_pkg::ADR_STATUS, rd);
		check_word("status", cplx_pkg::FIFO_DEPTH, rd);
		write_reg(cplx_pkg::ADR_OPA, $random(seed));
		write_reg(cplx_pkg::ADR_OPB, $random(seed));
		wb_write(cplx_pkg::ADR_CTRL, {30'd0, cplx_pkg::OP_CMUL}, STALL_WAIT, acked);
		if (acked) begin
			$display("ninth launch was acknowledged while the result fifo was full");
			errors++;
		end
		read_reg(cplx_pkg::ADR_RESULT, rd);
		write_reg(cplx_pkg::ADR_CTRL, {30'd0, cplx_pkg::OP_CMUL});
		wait_level(cplx_pkg::FIFO_DEPTH);
		for (int i = 0; i < cplx_pkg::FIFO_DEPTH; i++) begin
			read_reg(cplx_pkg::ADR_RESULT, rd);
		end

		// empty fifo read
		read_reg(cplx_pkg::ADR_STATUS, rd);
		check_word("status", 32'd0, rd);
		read_reg(cplx_pkg::ADR_RESULT, rd);
		check_word("res_o", 32'd0, rd);
		read_reg(cplx_pkg::ADR_STATUS, rd);
		check_word("status", 32'd0, rd);

		// reset with results still in flight
		for (int i = 0; i < 3; i++) begin
			launch_op($random(seed), $random(seed), cplx_pkg::OP_MUL);
		end
		@(negedge clk);
		rst_n = 1'b0;
		exp_q.delete();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		read_reg(cplx_pkg::ADR_STATUS, rd);
		check_word("status", 32'd0, rd);
		for (int i = 0; i < 10; i++) begin
			ra = $random(seed);
			rb = $random(seed);
			run_one(ra, rb, 2'(i % 3), rd);
		end

		if (exp_q.size() != 0) begin
			$display("%0d expected results were never read back", exp_q.size());
			errors++;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* hdl/cplx_unit_top.sv */
`timescale 1ns/100ps

module cplx_unit_top (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [cplx_pkg::ADR_W-1:0]  wb_adr_i,
	input  logic [cplx_pkg::CPLX_W-1:0] wb_dat_i,
	output logic [cplx_pkg::CPLX_W-1:0] wb_dat_o,
	output logic                        wb_ack_o
);

	logic                        op_valid;
	logic [cplx_pkg::CPLX_W-1:0] opa, opb;
	cplx_pkg::op_t               op;
	logic                        res_valid; // fifo push
	logic [cplx_pkg::CPLX_W-1:0] res;
	logic [cplx_pkg::LVL_W-1:0]  level;
	logic [cplx_pkg::CPLX_W-1:0] head;
	logic                        pop;

	//////////////////////////////
	cplx_wb_regs u_regs (
		.clk(clk), .rst_n_i(rst_n_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.op_valid_o(op_valid), .opa_o(opa), .opb_o(opb), .op_o(op),
		.res_valid_i(res_valid),
		.level_i(level), .head_i(head), .pop_o(pop)
	);

	complex_alu u_alu (
		.clk(clk), .rst_n_i(rst_n_i),
		.valid_i(op_valid), .opa_i(opa), .opb_i(opb), .op_i(op),
		.valid_o(res_valid), .res_o(res)
	);

	result_fifo u_fifo (
		.clk(clk), .rst_n_i(rst_n_i),
		.push_i(res_valid), .pop_i(pop), .din_i(res),
		.head_o(head), .level_o(level)
	);

endmodule

/* hdl/cplx_wb_regs.sv */
`timescale 1ns/100ps

module cplx_wb_regs (
	input  logic                        clk,
	input  logic                        rst_n_i,
	// wishbone classic slave
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [cplx_pkg::ADR_W-1:0]  wb_adr_i,
	input  logic [cplx_pkg::CPLX_W-1:0] wb_dat_i,
	output logic [cplx_pkg::CPLX_W-1:0] wb_dat_o,
	output logic                        wb_ack_o,
	// alu launch
	output logic                        op_valid_o,
	output logic [cplx_pkg::CPLX_W-1:0] opa_o,
	output logic [cplx_pkg::CPLX_W-1:0] opb_o,
	output cplx_pkg::op_t               op_o,
	input  logic                        res_valid_i,
	// result fifo
	input  logic [cplx_pkg::LVL_W-1:0]  level_i,
	input  logic [cplx_pkg::CPLX_W-1:0] head_i,
	output logic                        pop_o
);

	logic                       req;
	logic                       ctrl_wr;
	logic                       credit_ok;
	logic                       launch;
	logic [cplx_pkg::LVL_W-1:0] inflight_q;
	logic [cplx_pkg::LVL_W:0]   used; // level plus in flight with a spare bit

	//////////////////////////////
	// access decode
	assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o; // not yet acked
	assign ctrl_wr = req & wb_we_i & (wb_adr_i == cplx_pkg::ADR_CTRL);

	// every result in flight already owns a fifo slot
	assign used      = {1'b0, level_i} + {1'b0, inflight_q};
	assign credit_ok = (used < cplx_pkg::FIFO_DEPTH);
	assign launch    = ctrl_wr & credit_ok;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_ack_o   <= 1'b0;
			op_valid_o <= 1'b0;
		end else begin
			wb_ack_o   <= req & (~ctrl_wr | credit_ok); // stalled launch waits
			op_valid_o <= launch;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			inflight_q <= '0;
		end else begin
			case ({launch, res_valid_i})
				2'b10:   inflight_q <= inflight_q + 1'b1;
				2'b01:   inflight_q <= inflight_q - 1'b1;
				default: ;
			endcase
		end
	end

	//////////////////////////////
	// operand and opcode registers
	always_ff @(posedge clk) begin
		if (req & wb_we_i) begin
			case (wb_adr_i)
				cplx_pkg::ADR_OPA: opa_o <= wb_dat_i;
				cplx_pkg::ADR_OPB: opb_o <= wb_dat_i;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			op_o <= cplx_pkg::OP_MUL;
		end else if (launch) begin
			op_o <= cplx_pkg::op_t'(wb_dat_i[1:0]);
		end
	end

	//////////////////////////////
	// read data valid in the ack cycle
	always_comb begin
		wb_dat_o = '0;
		case (wb_adr_i)
			cplx_pkg::ADR_OPA: wb_dat_o = opa_o;
			cplx_pkg::ADR_OPB: wb_dat_o = opb_o;
			cplx_pkg::ADR_RESULT: begin
				if (level_i != '0) begin
					wb_dat_o = head_i;
				end
			end
			cplx_pkg::ADR_STATUS: begin
				wb_dat_o = {{(cplx_pkg::CPLX_W - cplx_pkg::LVL_W){1'b0}}, level_i};
			end
			default: ;
		endcase
	end

	// empty fifo reads back zero and leaves the pointers alone
	assign pop_o = wb_ack_o & wb_cyc_i & wb_stb_i & ~wb_we_i &
		(wb_adr_i == cplx_pkg::ADR_RESULT) & (level_i != '0);

	ack_single_a: assert property (
		@(posedge clk) disable iff (!rst_n_i)
			wb_ack_o |-> (wb_cyc_i && wb_stb_i) ##1 !wb_ack_o
	) else $error("cplx_wb_regs: ack outside a bus cycle or held for two cycles");

endmodule

/* hdl/result_fifo.sv */
`timescale 1ns/100ps

module result_fifo (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        push_i,
	input  logic                        pop_i,
	input  logic [cplx_pkg::CPLX_W-1:0] din_i,
	output logic [cplx_pkg::CPLX_W-1:0] head_o,
	output logic [cplx_pkg::LVL_W-1:0]  level_o
);

	logic [cplx_pkg::CPLX_W-1:0]               mem [cplx_pkg::FIFO_DEPTH];
	logic [$clog2(cplx_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(cplx_pkg::FIFO_DEPTH)-1:0]   rd_ptr;

	//////////////////////////////
	// storage
	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wr_ptr] <= din_i;
		end
	end

	assign head_o = mem[rd_ptr]; // oldest entry

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_i) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			level_o <= '0;
		end else begin
			case ({push_i, pop_i})
				2'b10:   level_o <= level_o + 1'b1;
				2'b01:   level_o <= level_o - 1'b1;
				default: ; // none or both
			endcase
		end
	end

	// credit logic upstream must keep these from ever firing
	no_push_full_a: assert property (
		@(posedge clk) disable iff (!rst_n_i) push_i |-> (level_o != cplx_pkg::FIFO_DEPTH)
	) else $error("result_fifo: push while full");

	no_pop_empty_a: assert property (
		@(posedge clk) disable iff (!rst_n_i) pop_i |-> (level_o != '0)
	) else $error("result_fifo: pop while empty");

endmodule

/* hdl/complex_alu.sv */
`timescale 1ns/100ps

module complex_alu (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic                        valid_i,
	input  logic [cplx_pkg::CPLX_W-1:0] opa_i,
	input  logic [cplx_pkg::CPLX_W-1:0] opb_i,
	input  cplx_pkg::op_t               op_i,
	output logic                        valid_o,
	output logic [cplx_pkg::CPLX_W-1:0] res_o
);

	logic [cplx_pkg::DATA_W-1:0] a, b, c, d;
	logic [cplx_pkg::DATA_W-1:0] s2_b; // second input of slice 2
	logic                        valid_s1;
	logic                        valid_s2;
	cplx_pkg::op_t               op_s1;
	cplx_pkg::op_t               op_s2;
	logic                        mult_s1;
	logic [cplx_pkg::PROD_W-1:0] p1, p2, p3, p4;
	logic [cplx_pkg::DATA_W-1:0] t1, t2, t3, t4;
	logic [cplx_pkg::DATA_W-1:0] re_d, im_d;

	assign a = opa_i[cplx_pkg::CPLX_W-1:cplx_pkg::DATA_W];
	assign b = opa_i[cplx_pkg::DATA_W-1:0];
	assign c = opb_i[cplx_pkg::CPLX_W-1:cplx_pkg::DATA_W];
	assign d = opb_i[cplx_pkg::DATA_W-1:0];

	// add passes c through slice 2 instead of multiplying by d
	assign s2_b = (op_i == cplx_pkg::OP_ADD) ? c : d;

	//////////////////////////////
	// control pipeline
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			valid_o  <= 1'b0;
			op_s1    <= cplx_pkg::OP_MUL;
			op_s2    <= cplx_pkg::OP_MUL;
		end else begin
			valid_s1 <= valid_i;
			valid_s2 <= valid_s1;
			valid_o  <= valid_s2;
			if (valid_i) begin
				op_s1 <= op_i;
			end
			op_s2 <= op_s1;
		end
	end

	assign mult_s1 = (op_s1 != cplx_pkg::OP_ADD); // applies in product cycle

	//////////////////////////////
	// slices multiply a*c, b*d, b*c and a*d or pass a, c, b and d for add
	dsp_slice u_slice_1 (
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a), .b_i(c),
		.ce_a_i(valid_i), .ce_b_i(valid_i),
		.use_mult_i(mult_s1), .sel_b_i(1'b0), .p_o(p1)
	);

	dsp_slice u_slice_2 (
		.clk(clk), .rst_n_i(rst_n_i), .a_i(b), .b_i(s2_b),
		.ce_a_i(valid_i), .ce_b_i(valid_i),
		.use_mult_i(mult_s1), .sel_b_i(1'b1), .p_o(p2)
	);

	dsp_slice u_slice_3 (
		.clk(clk), .rst_n_i(rst_n_i), .a_i(b), .b_i(c),
		.ce_a_i(valid_i), .ce_b_i(valid_i),
		.use_mult_i(mult_s1), .sel_b_i(1'b0), .p_o(p3)
	);

	dsp_slice u_slice_4 (
		.clk(clk), .rst_n_i(rst_n_i), .a_i(a), .b_i(d),
		.ce_a_i(valid_i), .ce_b_i(valid_i),
		.use_mult_i(mult_s1), .sel_b_i(1'b1), .p_o(p4)
	);

	//////////////////////////////
	// truncate and combine
	always_comb begin
		if (op_s2 == cplx_pkg::OP_ADD) begin
			t1 = p1[cplx_pkg::DATA_W-1:0]; // raw operands without shift
			t2 = p2[cplx_pkg::DATA_W-1:0];
			t3 = p3[cplx_pkg::DATA_W-1:0];
			t4 = p4[cplx_pkg::DATA_W-1:0];
		end else begin
			t1 = p1[cplx_pkg::FRAC_W+cplx_pkg::DATA_W-1:cplx_pkg::FRAC_W];
			t2 = p2[cplx_pkg::FRAC_W+cplx_pkg::DATA_W-1:cplx_pkg::FRAC_W];
			t3 = p3[cplx_pkg::FRAC_W+cplx_pkg::DATA_W-1:cplx_pkg::FRAC_W];
			t4 = p4[cplx_pkg::FRAC_W+cplx_pkg::DATA_W-1:cplx_pkg::FRAC_W];
		end
		case (op_s2)
			cplx_pkg::OP_CMUL: begin
				re_d = t1 + t2; // ac + bd
				im_d = t3 - t4; // bc - ad
			end
			cplx_pkg::OP_ADD: begin
				re_d = t1 + t2; // wraps
				im_d = t3 + t4;
			end
			default: begin
				re_d = t1 - t2;
				im_d = t3 + t4;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		res_o <= {re_d, im_d};
	end

	alu_lat_a: assert property (
		@(posedge clk) disable iff (!rst_n_i)
			valid_i |-> ##(cplx_pkg::ALU_LAT) (valid_o && !$isunknown(res_o))
	) else $error("complex_alu: no defined result %0d cycles after launch", cplx_pkg::ALU_LAT);

endmodule

/* hdl/dsp_slice.sv */
`timescale 1ns/100ps

module dsp_slice (
	input  logic                        clk,
	input  logic                        rst_n_i,
	input  logic [cplx_pkg::DATA_W-1:0] a_i,
	input  logic [cplx_pkg::DATA_W-1:0] b_i,
	input  logic                        ce_a_i,
	input  logic                        ce_b_i,
	input  logic                        use_mult_i,
	input  logic                        sel_b_i,
	output logic [cplx_pkg::PROD_W-1:0] p_o
);

	logic signed [cplx_pkg::DATA_W-1:0] a_q;
	logic signed [cplx_pkg::DATA_W-1:0] b_q;
	logic signed [cplx_pkg::PROD_W-1:0] mult;
	logic signed [cplx_pkg::DATA_W-1:0] pass_sel;
	logic        [cplx_pkg::PROD_W-1:0] pass_ext;

	//////////////////////////////
	// input register stage
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			a_q <= '0;
		end else if (ce_a_i) begin
			a_q <= a_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			b_q <= '0;
		end else if (ce_b_i) begin
			b_q <= b_i;
		end
	end

	//////////////////////////////
	// multiplier or bypass
	assign mult = a_q * b_q; // signed 16x16, full 32-bit result

	// bypass path for add, one operand sign extended
	assign pass_sel = sel_b_i ? b_q : a_q;
	assign pass_ext = {{(cplx_pkg::PROD_W - cplx_pkg::DATA_W){pass_sel[cplx_pkg::DATA_W-1]}},
		pass_sel};

	// product register, loads every cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			p_o <= '0;
		end else if (use_mult_i) begin
			p_o <= mult;
		end else begin
			p_o <= pass_ext;
		end
	end

	// X on an operand of a launched op shows up here one cycle later
	p_known_a: assert property (
		@(posedge clk) disable iff (!rst_n_i) !$isunknown(p_o)
	) else $error("dsp_slice: unknown value on p_o");

endmodule

/* hdl/cplx_pkg.sv */
package cplx_pkg;

	//////////////////////////////
	// data widths
	localparam int DATA_W = 16; // one Q1.15 part
	localparam int CPLX_W = 2 * DATA_W; // {re, im}
	localparam int PROD_W = 32;
	localparam int FRAC_W = 15; // product shift, truncating

	//////////////////////////////
	// register map, word addresses
	localparam int ADR_W = 3;
	localparam logic [ADR_W-1:0] ADR_OPA    = 3'd0;
	localparam logic [ADR_W-1:0] ADR_OPB    = 3'd1;
	localparam logic [ADR_W-1:0] ADR_CTRL   = 3'd2; // write launches
	localparam logic [ADR_W-1:0] ADR_RESULT = 3'd3; // read pops
	localparam logic [ADR_W-1:0] ADR_STATUS = 3'd4; // fifo level

	// operation codes, 3 behaves like OP_MUL
	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,
		OP_CMUL = 2'd1, // opa * conj(opb)
		OP_ADD  = 2'd2
	} op_t;

	//////////////////////////////
	// result buffering
	localparam int FIFO_DEPTH = 8;
	localparam int LVL_W      = 4; // holds 0..FIFO_DEPTH
	localparam int ALU_LAT    = 3; // op_valid to res_valid

endpackage
